// File: mpmul_pkg.sv
// ********************
// Multi-word multiplier shared definitions
// Operation mode, controller states and lane widths
// ********************

package mpmul_pkg;

   // Which half of the product is returned
   // Low half counts words from the least significant end
   // High half counts words from the most significant end
   typedef enum logic [0:0] {
      MODE_LOW  = 1'b0,
      MODE_HIGH = 1'b1
   } mul_mode_t;

   // Request handshake controller states
   typedef enum logic [1:0] {
      S_IDLE    = 2'd0,
      S_BUSY    = 2'd1,
      S_DONE    = 2'd2,
      S_RELEASE = 2'd3
   } ctrl_state_t;

   // DSP input lane, one bit wider than a word
   // The spare bit keeps 17-bit partial words
   localparam int LANE_W = 17;

   // Canonical word width
   localparam int WORD_W = 16;

endpackage

// File: multiplier.sv
// ********************
// Registered lane product
// One unsigned multiply mapped onto a single DSP slice
// ********************

`timescale 1ns/1ps

module multiplier #(
   parameter int A_W = 17,
   parameter int B_W = 17
) (
   input  logic               clk,
   input  logic [A_W-1:0]     a,
   input  logic [B_W-1:0]     b,
   output logic [A_W+B_W-1:0] p
);

   // Output register absorbed into the DSP
   always_ff @(posedge clk) begin
      p <= a * b;
   end

endmodule

// File: adder_tree_2_to_1.sv
// ********************
// Balanced adder tree
// Sums NUM_TERMS packed values into one, purely combinational
// ********************

`timescale 1ns/1ps

module adder_tree_2_to_1 #(
   parameter int NUM_TERMS = 4,
   parameter int SUM_W     = 37
) (
   input  logic [NUM_TERMS*SUM_W-1:0] terms,
   output logic [SUM_W-1:0]           sum
);

   // Split point, the upper half takes the odd term
   localparam int LO_TERMS = NUM_TERMS / 2;
   localparam int HI_TERMS = NUM_TERMS - LO_TERMS;

   generate
      if (NUM_TERMS == 1) begin : g_leaf
         // Single term passes straight through
         assign sum = terms;
      end else begin : g_node
         logic [SUM_W-1:0] sum_lo;
         logic [SUM_W-1:0] sum_hi;

         // Lower terms in the low bits of the bus
         adder_tree_2_to_1 #(
            .NUM_TERMS (LO_TERMS),
            .SUM_W     (SUM_W)
         ) u_lo (
            .terms (terms[LO_TERMS*SUM_W-1:0]),
            .sum   (sum_lo)
         );

         adder_tree_2_to_1 #(
            .NUM_TERMS (HI_TERMS),
            .SUM_W     (SUM_W)
         ) u_hi (
            .terms (terms[NUM_TERMS*SUM_W-1:LO_TERMS*SUM_W]),
            .sum   (sum_hi)
         );

         // SUM_W is sized by the caller to hold the full column
         assign sum = sum_lo + sum_hi;
      end
   endgenerate

endmodule

// File: half_multiply.sv
// ********************
// Half product of two multi-word operands
// DSP grid, column placement by mode, column adder trees
// and a registered first reduction to 17-bit words
// ********************

`timescale 1ns/1ps

module half_multiply #(
   parameter int NUM_ELEMENTS = 4,
   parameter int NUM_OUT      = 5,
   parameter int DSP_BIT_LEN  = mpmul_pkg::LANE_W,
   parameter int WORD_LEN     = mpmul_pkg::WORD_W
) (
   input  logic                             clk,
   input  mpmul_pkg::mul_mode_t             mode,
   input  logic [NUM_ELEMENTS*DSP_BIT_LEN-1:0] a,
   input  logic [NUM_ELEMENTS*DSP_BIT_LEN-1:0] b,
   output logic [NUM_OUT*DSP_BIT_LEN-1:0]   red_words
);

   import mpmul_pkg::*;

   localparam int PROD_W = 2 * DSP_BIT_LEN;
   // Column holds up to two parts per operand row
   localparam int ROWS   = 2 * NUM_ELEMENTS;
   localparam int SUM_W  = PROD_W + $clog2(ROWS);

   logic [PROD_W-1:0]     prod [NUM_ELEMENTS][NUM_ELEMENTS];
   logic [ROWS*SUM_W-1:0] col_terms [NUM_OUT];
   logic [SUM_W-1:0]      col_sum [NUM_OUT];
   logic [NUM_OUT*DSP_BIT_LEN-1:0] red_next;
   mul_mode_t             mode_r;

   // Mode follows the products through the DSP register
   always_ff @(posedge clk) begin
      mode_r <= mode;
   end

   // Only the triangle that reaches the output window is built
   // High mode feeds both operands in reversed word order
   generate
      for (genvar i = 0; i < NUM_ELEMENTS; i++) begin : g_row
         for (genvar j = 0; j < NUM_ELEMENTS; j++) begin : g_col
            if (i + j < NUM_OUT) begin : g_mul
               multiplier #(
                  .A_W (DSP_BIT_LEN),
                  .B_W (DSP_BIT_LEN)
               ) u_mul (
                  .clk (clk),
                  .a   ((mode == MODE_LOW) ? a[i*DSP_BIT_LEN +: DSP_BIT_LEN]
                        : a[(NUM_ELEMENTS-1-i)*DSP_BIT_LEN +: DSP_BIT_LEN]),
                  .b   ((mode == MODE_LOW) ? b[j*DSP_BIT_LEN +: DSP_BIT_LEN]
                        : b[(NUM_ELEMENTS-1-j)*DSP_BIT_LEN +: DSP_BIT_LEN]),
                  .p   (prod[i][j])
               );
            end else begin : g_none
               assign prod[i][j] = '0;
            end
         end
      end
   endgenerate

   // Column placement
   // Row 2i gets the part landing in column i+j, row 2i+1 the one in i+j+1
   // Low mode puts the low part near and the high part one column up
   // High mode counts from the top, so the high part stays near
   always_comb begin
      logic [SUM_W-1:0] lo_ext;
      logic [SUM_W-1:0] hi_ext;
      for (int c = 0; c < NUM_OUT; c++) begin
         col_terms[c] = '0;
      end
      for (int i = 0; i < NUM_ELEMENTS; i++) begin
         for (int j = 0; j < NUM_ELEMENTS; j++) begin
            if (i + j < NUM_OUT) begin
               lo_ext = SUM_W'(prod[i][j][WORD_LEN-1:0]);
               hi_ext = SUM_W'(prod[i][j][PROD_W-1:WORD_LEN]);
               col_terms[i+j][(2*i)*SUM_W +: SUM_W] =
                  (mode_r == MODE_LOW) ? lo_ext : hi_ext;
               // Part past the window is dropped
               if (i + j + 1 < NUM_OUT) begin
                  col_terms[i+j+1][(2*i+1)*SUM_W +: SUM_W] =
                     (mode_r == MODE_LOW) ? hi_ext : lo_ext;
               end
            end
         end
      end
   end

   // One tree per output column
   generate
      for (genvar c = 0; c < NUM_OUT; c++) begin : g_sum
         adder_tree_2_to_1 #(
            .NUM_TERMS (ROWS),
            .SUM_W     (SUM_W)
         ) u_tree (
            .terms (col_terms[c]),
            .sum   (col_sum[c])
         );
      end
   endgenerate

   // First reduction, low word plus the carry part of the lower-weight column
   // Result is a few counts above 16 bits at most, so 17 bits hold it
   always_comb begin
      logic [SUM_W-1:0] low_ext;
      logic [SUM_W-1:0] nb_carry;
      logic [SUM_W-1:0] acc;
      for (int c = 0; c < NUM_OUT; c++) begin
         low_ext  = SUM_W'(col_sum[c][WORD_LEN-1:0]);
         nb_carry = '0;
         if (mode_r == MODE_LOW && c > 0) begin
            nb_carry = col_sum[c-1] >> WORD_LEN;
         end else if (mode_r == MODE_HIGH && c < NUM_OUT - 1) begin
            nb_carry = col_sum[c+1] >> WORD_LEN;
         end
         acc = low_ext + nb_carry;
         red_next[c*DSP_BIT_LEN +: DSP_BIT_LEN] = acc[DSP_BIT_LEN-1:0];
      end
   end

   always_ff @(posedge clk) begin
      red_words <= red_next;
   end

endmodule

// File: word_normalize.sv
// ********************
// Word normalizer
// Ripples carries through 17-bit words and registers
// canonical 16-bit result words
// ********************

`timescale 1ns/1ps

module word_normalize #(
   parameter int NUM_OUT     = 5,
   parameter int DSP_BIT_LEN = mpmul_pkg::LANE_W,
   parameter int WORD_LEN    = mpmul_pkg::WORD_W
) (
   input  logic                           clk,
   input  mpmul_pkg::mul_mode_t           mode,
   input  logic [NUM_OUT*DSP_BIT_LEN-1:0] words,
   output logic [NUM_OUT*WORD_LEN-1:0]    result
);

   import mpmul_pkg::*;

   // Word plus incoming carry, one bit of headroom
   localparam int ACC_W   = DSP_BIT_LEN + 1;
   localparam int CARRY_W = ACC_W - WORD_LEN;

   logic [NUM_OUT*WORD_LEN-1:0] norm;

   // Single combinational carry chain
   // Low mode walks up from index 0, high mode walks down from the last index
   always_comb begin
      int                 idx;
      logic [ACC_W-1:0]   acc;
      logic [CARRY_W-1:0] carry;
      carry = '0;
      norm  = '0;
      for (int n = 0; n < NUM_OUT; n++) begin
         idx = (mode == MODE_LOW) ? n : NUM_OUT - 1 - n;
         acc = ACC_W'(words[idx*DSP_BIT_LEN +: DSP_BIT_LEN]) + ACC_W'(carry);
         norm[idx*WORD_LEN +: WORD_LEN] = acc[WORD_LEN-1:0];
         // Carry stays at 2 or below, the last one leaves the window
         carry = acc[ACC_W-1:WORD_LEN];
      end
   end

   // Result register, held while the inputs stay put
   always_ff @(posedge clk) begin
      result <= norm;
   end

endmodule

// File: mpmul_ctrl.sv
// ********************
// Multiplier request controller
// Four-phase req/ack, latches one operation and
// tracks the pipeline latency
// ********************

`timescale 1ns/1ps

module mpmul_ctrl #(
   parameter int NUM_ELEMENTS = 4,
   parameter int DSP_BIT_LEN  = mpmul_pkg::LANE_W,
   parameter int WORD_LEN     = mpmul_pkg::WORD_W
) (
   input  logic                                 clk,
   input  logic                                 rst_n,
   input  logic                                 req,
   input  mpmul_pkg::mul_mode_t                 mode,
   input  logic [NUM_ELEMENTS*WORD_LEN-1:0]     a,
   input  logic [NUM_ELEMENTS*WORD_LEN-1:0]     b,
   output logic                                 ack,
   output logic [NUM_ELEMENTS*DSP_BIT_LEN-1:0]  op_a,
   output logic [NUM_ELEMENTS*DSP_BIT_LEN-1:0]  op_b,
   output mpmul_pkg::mul_mode_t                 op_mode
);

   import mpmul_pkg::*;

   // Edges left after the accept edge before ack
   // Products, reduction, then normalize on the ack edge
   localparam logic [1:0] LAT_LOAD = 2'd2;

   ctrl_state_t state;
   logic [1:0]  lat_cnt;
   logic        accept;

   assign accept = (state == S_IDLE) && req;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state   <= S_IDLE;
         ack     <= 1'b0;
         lat_cnt <= '0;
      end else begin
         case (state)
            S_IDLE: begin
               if (req) begin
                  lat_cnt <= LAT_LOAD;
                  state   <= S_BUSY;
               end
            end
            S_BUSY: begin
               // ack rises together with the result register
               if (lat_cnt == 2'd0) begin
                  ack   <= 1'b1;
                  state <= S_DONE;
               end else begin
                  lat_cnt <= lat_cnt - 2'd1;
               end
            end
            S_DONE: begin
               // Back-pressure, hold ack until req drops
               if (!req) begin
                  ack   <= 1'b0;
                  state <= S_RELEASE;
               end
            end
            S_RELEASE: begin
               // req already seen low, one gap cycle before the next accept
               state <= S_IDLE;
            end
            default: state <= S_IDLE;
         endcase
      end
   end

   // Operand lanes, zero-extended words, fixed until the next accept
   always_ff @(posedge clk) begin
      if (accept) begin
         for (int w = 0; w < NUM_ELEMENTS; w++) begin
            op_a[w*DSP_BIT_LEN +: DSP_BIT_LEN] <= DSP_BIT_LEN'(a[w*WORD_LEN +: WORD_LEN]);
            op_b[w*DSP_BIT_LEN +: DSP_BIT_LEN] <= DSP_BIT_LEN'(b[w*WORD_LEN +: WORD_LEN]);
         end
         op_mode <= mode;
      end
   end

endmodule

// File: mpmul_top.sv
// ********************
// Multi-word multiplier top level
// Low words or high-word estimate of a by b over req/ack
// ********************

`timescale 1ns/1ps

module mpmul_top #(
   parameter int NUM_ELEMENTS = 4,
   // Between NUM_ELEMENTS and 2*NUM_ELEMENTS
   parameter int NUM_OUT      = 5,
   parameter int DSP_BIT_LEN  = mpmul_pkg::LANE_W,
   parameter int WORD_LEN     = mpmul_pkg::WORD_W
) (
   input  logic                             clk,
   input  logic                             rst_n,
   input  logic                             req,
   input  mpmul_pkg::mul_mode_t             mode,
   input  logic [NUM_ELEMENTS*WORD_LEN-1:0] a,
   input  logic [NUM_ELEMENTS*WORD_LEN-1:0] b,
   output logic                             ack,
   output logic [NUM_OUT*WORD_LEN-1:0]      result
);

   logic [NUM_ELEMENTS*DSP_BIT_LEN-1:0] op_a;
   logic [NUM_ELEMENTS*DSP_BIT_LEN-1:0] op_b;
   mpmul_pkg::mul_mode_t                op_mode;
   logic [NUM_OUT*DSP_BIT_LEN-1:0]      red_words;

   // Handshake and operand latch
   mpmul_ctrl #(
      .NUM_ELEMENTS (NUM_ELEMENTS),
      .DSP_BIT_LEN  (DSP_BIT_LEN),
      .WORD_LEN     (WORD_LEN)
   ) u_ctrl (
      .clk     (clk),
      .rst_n   (rst_n),
      .req     (req),
      .mode    (mode),
      .a       (a),
      .b       (b),
      .ack     (ack),
      .op_a    (op_a),
      .op_b    (op_b),
      .op_mode (op_mode)
   );

   // Products and first reduction, two edges
   half_multiply #(
      .NUM_ELEMENTS (NUM_ELEMENTS),
      .NUM_OUT      (NUM_OUT),
      .DSP_BIT_LEN  (DSP_BIT_LEN),
      .WORD_LEN     (WORD_LEN)
   ) u_half_mul (
      .clk       (clk),
      .mode      (op_mode),
      .a         (op_a),
      .b         (op_b),
      .red_words (red_words)
   );

   // Carry ripple, lands on the ack edge
   word_normalize #(
      .NUM_OUT     (NUM_OUT),
      .DSP_BIT_LEN (DSP_BIT_LEN),
      .WORD_LEN    (WORD_LEN)
   ) u_norm (
      .clk    (clk),
      .mode   (op_mode),
      .words  (red_words),
      .result (result)
   );

endmodule

// File: mpmul_checker.sv
// ********************
// Handshake checker for the multi-word multiplier
// Reset value, latency, hold and release of req/ack
// ********************

`timescale 1ns/1ps

module mpmul_checker #(
   parameter int RES_W = 80
) (
   input logic                  clk,
   input logic                  rst_n,
   input logic                  req,
   input logic                  ack,
   input logic [RES_W-1:0]      result,
   input mpmul_pkg::ctrl_state_t state
);

   import mpmul_pkg::*;

   // Failure count, read by the testbench at the end of the run
   int   assert_errors = 0;
   logic accept;

   // Edge that takes a new operation
   assign accept = (state == S_IDLE) && req;

   // Every reset cycle leaves ack low
   a_reset_ack: assert property (@(posedge clk) !rst_n |=> !ack)
      else begin
         $error("ack was high after a reset cycle");
         assert_errors++;
      end

   // ack lands on the third edge after the accept edge
   a_latency: assert property (@(posedge clk) disable iff (!rst_n)
      accept |=> !ack ##1 !ack ##1 !ack ##1 ack)
      else begin
         $error("ack did not rise three cycles after the accept edge");
         assert_errors++;
      end

   // Back-pressure keeps ack up
   a_hold: assert property (@(posedge clk) disable iff (!rst_n)
      (ack && req) |=> ack)
      else begin
         $error("ack dropped while req was still high");
         assert_errors++;
      end

   // Result frozen for the whole ack phase
   a_stable: assert property (@(posedge clk) disable iff (!rst_n)
      ack |=> (!ack || $stable(result)))
      else begin
         $error("result changed while ack was high");
         assert_errors++;
      end

   // Release one edge after req is seen low
   a_release: assert property (@(posedge clk) disable iff (!rst_n)
      (ack && !req) |=> !ack)
      else begin
         $error("ack did not fall one cycle after req went low");
         assert_errors++;
      end

endmodule

bind mpmul_top mpmul_checker #(
   .RES_W (NUM_OUT*WORD_LEN)
) u_checker (
   .clk    (clk),
   .rst_n  (rst_n),
   .req    (req),
   .ack    (ack),
   .result (result),
   .state  (u_ctrl.state)
);

// File: mpmul_tb.sv
// ********************
// Testbench for the multi-word multiplier
// Directed low, high, back-pressure and back-to-back
// operations checked against a reference model
// ********************

`timescale 1ns/1ps

module mpmul_tb;

   import mpmul_pkg::*;

   localparam int NUM_ELEMENTS = 4;
   localparam int NUM_OUT      = 5;
   localparam int WORD_LEN     = 16;
   localparam int OP_W         = NUM_ELEMENTS * WORD_LEN;
   localparam int RES_W        = NUM_OUT * WORD_LEN;
   localparam int ACC_W        = 2 * RES_W;
   // Run budget, about 60 operations of 8 cycles with a wide margin
   localparam int MAX_OPS      = 60;
   localparam int OP_CYCLES    = 8;
   localparam int CYCLE_LIMIT  = 4 * MAX_OPS * OP_CYCLES + 80;
   // Per-handshake wait bound
   localparam int ACK_WAIT     = 16;

   logic             clk;
   logic             rst_n;
   logic             req;
   mul_mode_t        mode;
   logic [OP_W-1:0]  a;
   logic [OP_W-1:0]  b;
   logic             ack;
   logic [RES_W-1:0] result;

   int          error_count = 0;
   int          check_count = 0;
   int          cycle_count = 0;
   int          total_errors;
   logic [15:0] lfsr_state  = 16'd66;

   mpmul_top dut (
      .clk    (clk),
      .rst_n  (rst_n),
      .req    (req),
      .mode   (mode),
      .a      (a),
      .b      (b),
      .ack    (ack),
      .result (result)
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   // Hard stop for a hung handshake
   always @(posedge clk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= CYCLE_LIMIT) begin
         $display("Timeout after %0d cycles, the run did not complete", cycle_count);
         $display("TEST FAILED");
         $finish;
      end
   end

   // Fibonacci LFSR, x^16 + x^14 + x^13 + x^11 + 1
   function automatic logic [15:0] lfsr_step(input logic [15:0] s);
      logic fb;
      fb = s[15] ^ s[13] ^ s[12] ^ s[10];
      return {s[14:0], fb};
   endfunction

   // One LFSR step per operand bit
   task automatic draw_operand(output logic [OP_W-1:0] v);
      v = '0;
      for (int n = 0; n < OP_W; n++) begin
         lfsr_state = lfsr_step(lfsr_state);
         v = {v[OP_W-2:0], lfsr_state[15]};
      end
   endtask

   // Reference model, straight from the word-product definition
   function automatic logic [RES_W-1:0] expected_result(input mul_mode_t m,
                                                        input logic [OP_W-1:0] x,
                                                        input logic [OP_W-1:0] y);
      logic [ACC_W-1:0]      acc;
      logic [2*WORD_LEN-1:0] p;
      logic [RES_W-1:0]      v;
      logic [RES_W-1:0]      r;
      int                    k;
      acc = '0;
      for (int i = 0; i < NUM_ELEMENTS; i++) begin
         for (int j = 0; j < NUM_ELEMENTS; j++) begin
            p = x[i*WORD_LEN +: WORD_LEN] * y[j*WORD_LEN +: WORD_LEN];
            if (m == MODE_LOW) begin
               if (i + j < NUM_OUT)
                  acc = acc + (ACC_W'(p) << (WORD_LEN * (i + j)));
            end else begin
               // Column counted from the top word of both operands
               k = (NUM_ELEMENTS - 1 - i) + (NUM_ELEMENTS - 1 - j);
               if (k < NUM_OUT)
                  acc = acc + (ACC_W'(p[2*WORD_LEN-1:WORD_LEN]) << (WORD_LEN * (NUM_OUT - 1 - k)));
               if (k < NUM_OUT - 1)
                  acc = acc + (ACC_W'(p[WORD_LEN-1:0]) << (WORD_LEN * (NUM_OUT - 2 - k)));
            end
         end
      end
      v = acc[RES_W-1:0];
      if (m == MODE_LOW)
         return v;
      // High mode, word 0 is the most significant
      for (int n = 0; n < NUM_OUT; n++)
         r[n*WORD_LEN +: WORD_LEN] = v[(NUM_OUT-1-n)*WORD_LEN +: WORD_LEN];
      return r;
   endfunction

   task automatic check_value(input string name, input logic [RES_W-1:0] got,
                              input logic [RES_W-1:0] exp);
      check_count++;
      if (got !== exp) begin
         error_count++;
         $display("Mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp);
      end
   endtask

   task automatic report_failure(input string what);
      error_count++;
      $display("Error at %0t ns: %s", $time, what);
   endtask

   // One full four-phase operation, hold_cycles of extra req after ack
   task automatic run_op(input mul_mode_t m, input logic [OP_W-1:0] x,
                         input logic [OP_W-1:0] y, input int hold_cycles);
      logic [RES_W-1:0] exp;
      int               waited;
      exp = expected_result(m, x, y);
      @(posedge clk);
      req  <= 1'b1;
      mode <= m;
      a    <= x;
      b    <= y;
      waited = 0;
      @(negedge clk);
      while (!ack && waited < ACK_WAIT) begin
         @(negedge clk);
         waited++;
      end
      if (!ack) begin
         report_failure($sformatf("ack did not rise within %0d cycles", ACK_WAIT));
         @(posedge clk);
         req <= 1'b0;
      end else begin
         // Request edge, accept edge, then three pipeline edges
         check_value("ack latency", waited, 4);
         check_value("result", result, exp);
         repeat (hold_cycles) begin
            @(negedge clk);
            check_value("ack", ack, 1'b1);
            check_value("result", result, exp);
         end
         @(posedge clk);
         req <= 1'b0;
         waited = 0;
         @(negedge clk);
         while (ack && waited < ACK_WAIT) begin
            @(negedge clk);
            waited++;
         end
         if (ack)
            report_failure("ack stayed high after req was lowered");
         else
            check_value("ack release", waited, 1);
      end
   endtask

   task automatic end_test(input string name, input int errors_before);
      $display("Test %s finished, %0d errors", name, error_count - errors_before);
   endtask

   task automatic test_small_low();
      int start;
      start = error_count;
      @(negedge clk);
      check_value("ack", ack, 1'b0);
      run_op(MODE_LOW, OP_W'(3), OP_W'(5), 0);
      // Two-word operands, cross terms land in words 1 and 2
      run_op(MODE_LOW, {32'd0, 16'd7, 16'd2}, {32'd0, 16'd9, 16'd4}, 0);
      end_test("small_low", start);
   endtask

   task automatic test_low_carry();
      int              start;
      logic [OP_W-1:0] x;
      logic [OP_W-1:0] y;
      start = error_count;
      run_op(MODE_LOW, '1, '1, 0);
      repeat (10) begin
         draw_operand(x);
         draw_operand(y);
         run_op(MODE_LOW, x, y, 0);
      end
      end_test("low_carry", start);
   endtask

   task automatic test_high_mode();
      int              start;
      logic [OP_W-1:0] x;
      logic [OP_W-1:0] y;
      start = error_count;
      run_op(MODE_HIGH, '1, '1, 0);
      repeat (10) begin
         draw_operand(x);
         draw_operand(y);
         run_op(MODE_HIGH, x, y, 0);
      end
      end_test("high_mode", start);
   endtask

   task automatic test_back_pressure();
      int              start;
      logic [OP_W-1:0] x;
      logic [OP_W-1:0] y;
      start = error_count;
      draw_operand(x);
      draw_operand(y);
      run_op(MODE_LOW, x, y, 5);
      draw_operand(x);
      draw_operand(y);
      run_op(MODE_HIGH, x, y, 5);
      end_test("back_pressure", start);
   endtask

   task automatic test_back_to_back();
      int              start;
      logic [OP_W-1:0] x;
      logic [OP_W-1:0] y;
      mul_mode_t       m;
      start = error_count;
      m = MODE_HIGH;
      // All-ones then small words, stale carries would show up here
      run_op(MODE_LOW, '1, '1, 0);
      run_op(MODE_HIGH, OP_W'(1), OP_W'(1), 0);
      repeat (6) begin
         draw_operand(x);
         draw_operand(y);
         m = (m == MODE_LOW) ? MODE_HIGH : MODE_LOW;
         run_op(m, x, y, 0);
      end
      end_test("back_to_back", start);
   endtask

   initial begin
      rst_n = 1'b0;
      req   = 1'b0;
      mode  = MODE_LOW;
      a     = '0;
      b     = '0;
      repeat (5) @(posedge clk);
      rst_n <= 1'b1;
      test_small_low();
      test_low_carry();
      test_high_mode();
      test_back_pressure();
      test_back_to_back();
      @(negedge clk);
      total_errors = error_count + dut.u_checker.assert_errors;
      $display("Checks %0d, errors %0d, assertion failures %0d", check_count, error_count,
               dut.u_checker.assert_errors);
      if (total_errors == 0)
         $display("TEST OK");
      else
         $display("TEST FAILED");
      $finish;
   end

endmodule

// File: build.f
mpmul_pkg.sv
multiplier.sv
adder_tree_2_to_1.sv
half_multiply.sv
word_normalize.sv
mpmul_ctrl.sv
mpmul_top.sv
mpmul_checker.sv
mpmul_tb.sv
